/* rtl/quadAddressGen.sv */
// ==========================================================
// Read address generation for the texel quad
// Per-axis index, wrapped neighbour index and clamp detection
// Even/odd bank routing of both quad rows
// Registered corner parity, clamp flags and sub coordinates
// ==========================================================
module quadAddressGen
(
    input  logic                  aclk,

    input  texturePkg::coordT     texelS,  // Q1.15
    input  texturePkg::coordT     texelT,  // Q1.15
    input  logic                  clampS,
    input  logic                  clampT,
    input  texturePkg::sizeLog2T  widthLog2,
    input  texturePkg::sizeLog2T  heightLog2,

    output texturePkg::bankAddrT  evenAddrA,
    output texturePkg::bankAddrT  oddAddrA,
    output texturePkg::bankAddrT  evenAddrB,
    output texturePkg::bankAddrT  oddAddrB,

    output logic [3 : 0]          cornerOdd, // 00, 01, 10, 11 from bit 0 up
    output logic                  clampSOut,
    output logic                  clampTOut,
    output texturePkg::coordT     subCoordS, // Q0.16
    output texturePkg::coordT     subCoordT  // Q0.16
);
    import texturePkg::*;

    logic [maxSizeLog2 - 1 : 0]   sIdx0;
    logic [maxSizeLog2 - 1 : 0]   sIdx1;
    logic [maxSizeLog2 - 1 : 0]   tIdx0;
    logic [maxSizeLog2 - 1 : 0]   tIdx1;
    logic [16 : 0]                sumS;
    logic [16 : 0]                sumT;
    logic [texelIdxWidth - 1 : 0] idx00;
    logic [texelIdxWidth - 1 : 0] idx01;
    logic [texelIdxWidth - 1 : 0] idx10;
    logic [texelIdxWidth - 1 : 0] idx11;

    // Integer texel index out of the fractional part of a Q1.15 coordinate
    function automatic logic [maxSizeLog2 - 1 : 0] axisIndex
    (
        input logic [14 : 0] frac,
        input sizeLog2T      sizeLog2
    );
        logic [3 : 0]  shiftAmount;
        logic [14 : 0] shifted;
        shiftAmount = 4'd15 - {1'b0, sizeLog2};
        shifted = frac >> shiftAmount;
        return shifted[maxSizeLog2 - 1 : 0];
    endfunction

    // Coordinate advanced by one texel, with the carry kept
    function automatic logic [16 : 0] neighbourSum
    (
        input coordT    coord,
        input sizeLog2T sizeLog2
    );
        logic [3 : 0] shiftAmount;
        shiftAmount = 4'd15 - {1'b0, sizeLog2};
        return {1'b0, coord} + (17'd1 << shiftAmount);
    endfunction

    // Remaining fraction inside the texel as Q0.16
    function automatic coordT subCoord
    (
        input coordT    coord,
        input sizeLog2T sizeLog2
    );
        coordT scaled;
        scaled = {coord[14 : 0], 1'b0} << sizeLog2;
        return (sizeLog2 == '0) ? '0 : scaled;
    endfunction

    assign sumS = neighbourSum(texelS, widthLog2);
    assign sumT = neighbourSum(texelT, heightLog2);

    // Neighbour wraps since only the bits below 15 are kept
    assign sIdx0 = axisIndex(texelS[14 : 0], widthLog2);
    assign sIdx1 = axisIndex(sumS[14 : 0], widthLog2);
    assign tIdx0 = axisIndex(texelT[14 : 0], heightLog2);
    assign tIdx1 = axisIndex(sumT[14 : 0], heightLog2);

    // Row major, t times width plus s
    assign idx00 = (texelIdxWidth'(tIdx0) << widthLog2) | texelIdxWidth'(sIdx0);
    assign idx01 = (texelIdxWidth'(tIdx0) << widthLog2) | texelIdxWidth'(sIdx1);
    assign idx10 = (texelIdxWidth'(tIdx1) << widthLog2) | texelIdxWidth'(sIdx0);
    assign idx11 = (texelIdxWidth'(tIdx1) << widthLog2) | texelIdxWidth'(sIdx1);

    // Adjacent s texels always sit in opposite banks
    assign evenAddrA = idx00[0] ? idx01[texelIdxWidth - 1 : 1] : idx00[texelIdxWidth - 1 : 1];
    assign oddAddrA  = idx00[0] ? idx00[texelIdxWidth - 1 : 1] : idx01[texelIdxWidth - 1 : 1];
    assign evenAddrB = idx10[0] ? idx11[texelIdxWidth - 1 : 1] : idx10[texelIdxWidth - 1 : 1];
    assign oddAddrB  = idx10[0] ? idx10[texelIdxWidth - 1 : 1] : idx11[texelIdxWidth - 1 : 1];

    // Lines up with the bank read data
    always_ff @(posedge aclk)
    begin
        cornerOdd <= {idx11[0], idx10[0], idx01[0], idx00[0]};

        // Step crossed the far edge, either into bit 15 or out of the word
        clampSOut <= clampS && (sumS[16] || (sumS[15] && !texelS[15]));
        clampTOut <= clampT && (sumT[16] || (sumT[15] && !texelT[15]));

        subCoordS <= subCoord(texelS, widthLog2);
        subCoordT <= subCoord(texelT, heightLog2);
    end

endmodule

/* rtl/quadAssembler.sv */
// ==========================================================
// Texel quad assembly after the bank read
// Bank demux per corner and quad clamping
// RGBA4444 to RGBA8888 expansion of all four texels
// ==========================================================
module quadAssembler
(
    input  logic [3 : 0]          cornerOdd,
    input  logic                  clampS,
    input  logic                  clampT,

    input  texturePkg::texelT     evenDataA, // Row t0
    input  texturePkg::texelT     oddDataA,
    input  texturePkg::texelT     evenDataB, // Row t1
    input  texturePkg::texelT     oddDataB,

    output texturePkg::expTexelT  texel00,
    output texturePkg::expTexelT  texel01,
    output texturePkg::expTexelT  texel10,
    output texturePkg::expTexelT  texel11
);
    import texturePkg::*;

    localparam int extraBits = expandedSubPixelWidth - subPixelWidth;

    texelT select00;
    texelT select01;
    texelT select10;
    texelT select11;

    texelT clamped01;
    texelT clamped10;
    texelT clamped11;

    // Fill the low bits with the top of the same channel
    function automatic expTexelT expand
    (
        input texelT texel
    );
        expTexelT result;
        logic [subPixelWidth - 1 : 0] channel;
        result = '0;
        for (int i = 0; i < numSubPixels; i++)
        begin
            channel = texel[i * subPixelWidth +: subPixelWidth];
            result[i * expandedSubPixelWidth +: expandedSubPixelWidth] =
                {channel, channel[subPixelWidth - 1 -: extraBits]};
        end
        return result;
    endfunction

    // Each corner reads the bank its parity points to
    assign select00 = cornerOdd[0] ? oddDataA : evenDataA;
    assign select01 = cornerOdd[1] ? oddDataA : evenDataA;
    assign select10 = cornerOdd[2] ? oddDataB : evenDataB;
    assign select11 = cornerOdd[3] ? oddDataB : evenDataB;

    // Clamp at the far edge
    assign clamped01 = clampS ? select00 : select01;
    assign clamped10 = clampT ? select00 : select10;

    always_comb
    begin
        if (clampS)
            clamped11 = clamped10; // Covers the corner clamped in both axes
        else if (clampT)
            clamped11 = select01;
        else
            clamped11 = select11;
    end

    assign texel00 = expand(select00);
    assign texel01 = expand(clamped01);
    assign texel10 = expand(clamped10);
    assign texel11 = expand(clamped11);

endmodule

/* rtl/texelBank.sv */
// ==========================================================
// One texel RAM bank
// Port A is a registered read
// Port B writes when enabled, otherwise a registered read
// ==========================================================
module texelBank
(
    input  logic                  aclk,

    input  logic                  writeEn,
    input  texturePkg::bankAddrT  writeAddr,
    input  texturePkg::texelT     writeData,

    input  texturePkg::bankAddrT  readAddrA,
    input  texturePkg::bankAddrT  readAddrB,
    output texturePkg::texelT     readDataA,
    output texturePkg::texelT     readDataB
);
    import texturePkg::*;

    texelT mem [bankDepth];

    // Row t0 of the quad
    always_ff @(posedge aclk)
    begin
        readDataA <= mem[readAddrA];
    end

    // Row t1 of the quad, shared with the loader
    always_ff @(posedge aclk)
    begin
        if (writeEn)
        begin
            mem[writeAddr] <= writeData;
        end
        else
        begin
            readDataB <= mem[readAddrB]; // Holds its last value during writes
        end
    end

endmodule

/* rtl/textureBuffer.sv */
// ==========================================================
// Texture buffer top level
// Stream loader, even and odd texel banks
// Quad address generator and quad assembler
// ==========================================================
module textureBuffer
(
    input  logic                  aclk,
    input  logic                  resetn,

    // Texture load
    input  logic                  streamValid,
    input  logic                  streamLast,
    input  texturePkg::streamT    streamData,
    output logic                  streamReady,

    // Quad read
    input  texturePkg::coordT     texelS,  // Q1.15
    input  texturePkg::coordT     texelT,  // Q1.15
    input  logic                  clampS,
    input  logic                  clampT,
    input  texturePkg::sizeLog2T  widthLog2,
    input  texturePkg::sizeLog2T  heightLog2,

    output texturePkg::expTexelT  texel00, // (s, t)
    output texturePkg::expTexelT  texel01, // (s + 1, t)
    output texturePkg::expTexelT  texel10, // (s, t + 1)
    output texturePkg::expTexelT  texel11, // (s + 1, t + 1)
    output texturePkg::coordT     subCoordS, // Q0.16
    output texturePkg::coordT     subCoordT  // Q0.16
);
    import texturePkg::*;

    logic              writeEn;
    bankAddrT          writeAddr;
    texturePkg::texelT evenTexel; // The texelT port hides the type name here
    texturePkg::texelT oddTexel;

    bankAddrT          evenAddrA;
    bankAddrT          oddAddrA;
    bankAddrT          evenAddrB;
    bankAddrT          oddAddrB;

    texturePkg::texelT evenDataA;
    texturePkg::texelT oddDataA;
    texturePkg::texelT evenDataB;
    texturePkg::texelT oddDataB;

    logic [3 : 0]      cornerOdd;
    logic              clampSReg;
    logic              clampTReg;

    textureLoader loader (
        .aclk        (aclk),
        .resetn      (resetn),
        .streamValid (streamValid),
        .streamLast  (streamLast),
        .streamData  (streamData),
        .streamReady (streamReady),
        .writeEn     (writeEn),
        .writeAddr   (writeAddr),
        .evenTexel   (evenTexel),
        .oddTexel    (oddTexel)
    );

    texelBank evenBank (
        .aclk      (aclk),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (evenTexel),
        .readAddrA (evenAddrA),
        .readAddrB (evenAddrB),
        .readDataA (evenDataA),
        .readDataB (evenDataB)
    );

    texelBank oddBank (
        .aclk      (aclk),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (oddTexel),
        .readAddrA (oddAddrA),
        .readAddrB (oddAddrB),
        .readDataA (oddDataA),
        .readDataB (oddDataB)
    );

    quadAddressGen addressGen (
        .aclk       (aclk),
        .texelS     (texelS),
        .texelT     (texelT),
        .clampS     (clampS),
        .clampT     (clampT),
        .widthLog2  (widthLog2),
        .heightLog2 (heightLog2),
        .evenAddrA  (evenAddrA),
        .oddAddrA   (oddAddrA),
        .evenAddrB  (evenAddrB),
        .oddAddrB   (oddAddrB),
        .cornerOdd  (cornerOdd),
        .clampSOut  (clampSReg),
        .clampTOut  (clampTReg),
        .subCoordS  (subCoordS),
        .subCoordT  (subCoordT)
    );

    quadAssembler assembler (
        .cornerOdd (cornerOdd),
        .clampS    (clampSReg),
        .clampT    (clampTReg),
        .evenDataA (evenDataA),
        .oddDataA  (oddDataA),
        .evenDataB (evenDataB),
        .oddDataB  (oddDataB),
        .texel00   (texel00),
        .texel01   (texel01),
        .texel10   (texel10),
        .texel11   (texel11)
    );

endmodule

/* rtl/textureLoader.sv */
// ==========================================================
// Write side of the texture buffer
// Bank address counter with restart after the last beat
// Ready flag and even/odd split of each stream beat
// ==========================================================
module textureLoader
(
    input  logic                  aclk,
    input  logic                  resetn,

    input  logic                  streamValid,
    input  logic                  streamLast,
    input  texturePkg::streamT    streamData,
    output logic                  streamReady,

    output logic                  writeEn,
    output texturePkg::bankAddrT  writeAddr,
    output texturePkg::texelT     evenTexel,
    output texturePkg::texelT     oddTexel
);
    import texturePkg::*;

    // No back-pressure, ready only drops while in reset
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            streamReady <= 1'b0;
        end
        else
        begin
            streamReady <= 1'b1;
        end
    end

    assign writeEn = streamValid && streamReady;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writeAddr <= '0;
        end
        else if (writeEn)
        begin
            if (streamLast)
                writeAddr <= '0; // Next texture starts at the bank origin
            else
                writeAddr <= writeAddr + 1'b1;
        end
    end

    // Both texels of a beat share one bank address
    assign evenTexel = streamData[0 +: texelWidth];
    assign oddTexel  = streamData[texelWidth +: texelWidth];

endmodule

/* rtl/texturePkg.sv */
// ==========================================================
// Texture buffer shared definitions
// Size limits, colour channel widths and bank geometry
// Texel, coordinate, address and stream types
// ==========================================================
package texturePkg;

    // Texture size limits, 64 texels per axis at most
    localparam int maxSizeLog2 = 6;
    localparam int texelIdxWidth = 2 * maxSizeLog2; // Linear index into a full texture

    // Colour channels
    localparam int subPixelWidth = 4;
    localparam int expandedSubPixelWidth = 8;
    localparam int numSubPixels = 4;
    localparam int texelWidth = subPixelWidth * numSubPixels;
    localparam int expTexelWidth = expandedSubPixelWidth * numSubPixels;

    // Even s texels in one bank, odd s texels in the other
    localparam int bankDepth = 2048;
    localparam int bankAddrWidth = $clog2(bankDepth);

    localparam int streamWidth = 2 * texelWidth; // Two texels per beat

    // Stored RGBA4444 texel
    typedef logic [texelWidth - 1 : 0] texelT;

    // RGBA8888 after nibble replication
    typedef logic [expTexelWidth - 1 : 0] expTexelT;

    // Q1.15 on the way in, Q0.16 for the sub coordinates
    typedef logic [15 : 0] coordT;

    // 0 means 1 texel, 6 means 64 texels
    typedef logic [2 : 0] sizeLog2T;

    typedef logic [bankAddrWidth - 1 : 0] bankAddrT;

    // One write beat, low half is the even texel
    typedef logic [streamWidth - 1 : 0] streamT;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the texture buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module textureBufferTb -f textureBuffer.f -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/VtextureBufferTb > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

/* test/textureBufferTb.sv */
// ==========================================================
// Texture buffer testbench
// Clock, reset, LFSR texel source and reference texture
// Directed tests for load, quad read, wrap and clamp,
// sub coordinates, colour expansion and load restart
// ==========================================================
module textureBufferTb;
    import texturePkg::*;

    logic       aclk;
    logic       resetn;
    logic       streamValid;
    logic       streamLast;
    streamT     streamData;
    logic       streamReady;
    coordT      readS;
    coordT      readT;
    logic       clampS;
    logic       clampT;
    sizeLog2T   widthLog2;
    sizeLog2T   heightLog2;
    expTexelT   texel00;
    expTexelT   texel01;
    expTexelT   texel10;
    expTexelT   texel11;
    coordT      subCoordS;
    coordT      subCoordT;

    logic [15 : 0] refTex [4096]; // Row major, t times width plus s
    logic [31 : 0] lfsr;

    textureBuffer uut (
        .aclk        (aclk),
        .resetn      (resetn),
        .streamValid (streamValid),
        .streamLast  (streamLast),
        .streamData  (streamData),
        .streamReady (streamReady),
        .texelS      (readS),
        .texelT      (readT),
        .clampS      (clampS),
        .clampT      (clampT),
        .widthLog2   (widthLog2),
        .heightLog2  (heightLog2),
        .texel00     (texel00),
        .texel01     (texel01),
        .texel10     (texel10),
        .texel11     (texel11),
        .subCoordS   (subCoordS),
        .subCoordT   (subCoordT)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31 : 0] lfsrStep(input logic [31 : 0] state);
        return {state[30 : 0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [15 : 0] randomTexel();
        logic [15 : 0] value;
        value = '0;
        for (int i = 0; i < 16; i++)
        begin
            lfsr = lfsrStep(lfsr);
            value = {value[14 : 0], lfsr[0]}; // One step per bit
        end
        return value;
    endfunction

    // Channel c becomes cc
    function automatic logic [31 : 0] expandTexel(input logic [15 : 0] texel);
        logic [31 : 0] result;
        for (int i = 0; i < 4; i++)
            result[8 * i +: 8] = texel[4 * i +: 4] * 8'h11;
        return result;
    endfunction

    function automatic logic [15 : 0] subCoordExpected(input logic [15 : 0] coord,
                                                       input int sizeLog2);
        int frac;
        frac = coord & ((1 << (15 - sizeLog2)) - 1);
        return (sizeLog2 == 0) ? 16'h0 : 16'(frac << (sizeLog2 + 1));
    endfunction

    task automatic checkValue(input string testName, input logic [31 : 0] expected,
                              input logic [31 : 0] actual);
        if (actual !== expected)
        begin
            $display("ERROR: %s expected %h actual %h", testName, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch in %s", testName);
        end
    endtask

    task automatic waitReady(input string what);
        int cycles;
        cycles = 0;
        while (!streamReady && cycles < 32)
        begin
            @(negedge aclk);
            cycles++;
        end
        if (!streamReady)
        begin
            $display("Timeout: streamReady stayed low %s", what);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout waiting for streamReady");
        end
    endtask

    task automatic fillRandom(input int count);
        for (int i = 0; i < count; i++)
            refTex[i] = randomTexel();
    endtask

    // Two texels per beat, last beat flagged
    task automatic streamTexels(input int count);
        for (int k = 0; k < count / 2; k++)
        begin
            waitReady("during the texture load");
            streamValid = 1'b1;
            streamLast  = (k == count / 2 - 1);
            streamData  = {refTex[2 * k + 1], refTex[2 * k]};
            @(posedge aclk);
            @(negedge aclk);
        end
        streamValid = 1'b0;
        streamLast  = 1'b0;
    endtask

    // One read, result sampled one cycle later
    task automatic readQuad(input string testName, input logic [15 : 0] s,
                            input logic [15 : 0] t, input logic cs, input logic ct,
                            input int wl, input int hl, input logic checkTexels);
        int width;
        int sIdx0;
        int sIdx1;
        int tIdx0;
        int tIdx1;
        logic clampSExp;
        logic clampTExp;
        logic [15 : 0] q00;
        logic [15 : 0] q01;
        logic [15 : 0] q10;
        logic [15 : 0] q11;
        readS      = s;
        readT      = t;
        clampS     = cs;
        clampT     = ct;
        widthLog2  = 3'(wl);
        heightLog2 = 3'(hl);
        @(posedge aclk);
        @(negedge aclk);
        width = 1 << wl;
        sIdx0 = (s & 16'h7fff) >> (15 - wl);
        sIdx1 = (sIdx0 + 1) % width; // Wrap at the far edge
        tIdx0 = (t & 16'h7fff) >> (15 - hl);
        tIdx1 = (tIdx0 + 1) % (1 << hl);
        clampSExp = cs && ((s & 16'h7fff) + (1 << (15 - wl)) >= 'h8000);
        clampTExp = ct && ((t & 16'h7fff) + (1 << (15 - hl)) >= 'h8000);
        q00 = refTex[tIdx0 * width + sIdx0];
        q01 = clampSExp ? q00 : refTex[tIdx0 * width + sIdx1];
        q10 = clampTExp ? q00 : refTex[tIdx1 * width + sIdx0];
        q11 = clampSExp ? q10 : (clampTExp ? q01 : refTex[tIdx1 * width + sIdx1]);
        if (checkTexels)
        begin
            checkValue(testName, expandTexel(q00), texel00);
            checkValue(testName, expandTexel(q01), texel01);
            checkValue(testName, expandTexel(q10), texel10);
            checkValue(testName, expandTexel(q11), texel11);
        end
        checkValue(testName, {16'h0, subCoordExpected(s, wl)}, {16'h0, subCoordS});
        checkValue(testName, {16'h0, subCoordExpected(t, hl)}, {16'h0, subCoordT});
    endtask

    task automatic resetAndReady();
        resetn = 1'b0;
        repeat (8)
        begin
            @(negedge aclk);
            checkValue("reset and ready", 32'd0, {31'd0, streamReady});
        end
        resetn = 1'b1;
        waitReady("after reset");
    endtask

    task automatic loadAndRead();
        logic [15 : 0] s;
        logic [15 : 0] t;
        fillRandom(64);
        refTex[0] = 16'hf0a0; // Channel values 0x0, 0xF and 0xA
        refTex[1] = 16'h0af5;
        refTex[8] = 16'ha0f0;
        refTex[9] = 16'h5f0a;
        streamTexels(64);
        for (int i = 0; i < 8; i++)
        begin
            s = 16'((i << 12) | 'h800);
            t = 16'((((3 * i) % 8) << 12) | 'h800);
            readQuad("plain read centre", s, t, 1'b0, 1'b0, 3, 3, 1'b1);
            s = 16'((i << 12) | 'hc40);
            t = 16'((((5 * i) % 8) << 12) | 'h1a0);
            readQuad("plain read between", s, t, 1'b0, 1'b0, 3, 3, 1'b1);
        end
    endtask

    task automatic colourExpansion();
        readQuad("colour expansion", 16'h0800, 16'h0800, 1'b0, 1'b0, 3, 3, 1'b1);
        checkValue("colour expansion", 32'hff00aa00, texel00);
        checkValue("colour expansion", 32'h00aaff55, texel01);
        checkValue("colour expansion", 32'haa00ff00, texel10);
        checkValue("colour expansion", 32'h55ff00aa, texel11);
    endtask

    // 16x4 texture, last column is 15 and last row is 3
    task automatic wrapAndClamp();
        fillRandom(64);
        streamTexels(64);
        readQuad("wrap corner", 16'h7c00, 16'h7000, 1'b0, 1'b0, 4, 2, 1'b1);
        checkValue("wrap to column 0", expandTexel(refTex[48]), texel01);
        checkValue("wrap to row 0", expandTexel(refTex[15]), texel10);
        checkValue("wrap to both", expandTexel(refTex[0]), texel11);
        for (int mode = 1; mode < 4; mode++)
        begin
            readQuad("clamp corner", 16'h7c00, 16'h7000, mode[0], mode[1], 4, 2, 1'b1);
            readQuad("clamp last column", 16'h7a00, 16'h2400, mode[0], mode[1], 4, 2, 1'b1);
            readQuad("clamp last row", 16'h3300, 16'h6800, mode[0], mode[1], 4, 2, 1'b1);
        end
    endtask

    task automatic subCoordinates();
        int sizes [5] = '{0, 1, 3, 5, 6};
        for (int a = 0; a < 5; a++)
        begin
            readQuad("sub coordinates", 16'h5a5b, 16'h2c3d, 1'b0, 1'b0,
                     sizes[a], sizes[(a + 2) % 5], 1'b0);
            readQuad("sub coordinates", 16'h7fff, 16'h0001, 1'b0, 1'b0,
                     sizes[(a + 4) % 5], sizes[a], 1'b0);
        end
    endtask

    // 4x4 over the 16x4 texture, rows 1 to 3 of the old layout stay
    task automatic restartOnLast();
        fillRandom(16);
        streamTexels(16);
        for (int i = 0; i < 16; i++)
            readQuad("restart new texture", 16'(((i % 4) << 13) | 'h1000),
                     16'(((i / 4) << 13) | 'h1000), 1'b0, 1'b0, 2, 2, 1'b1);
        for (int i = 1; i < 4; i++)
            readQuad("restart old entries", 16'(((5 * i) << 11) | 'h400),
                     16'((i << 13) | 'h400), 1'b0, 1'b0, 4, 2, 1'b1);
    endtask

    initial
    begin
        lfsr        = 32'h38e0;
        resetn      = 1'b0;
        streamValid = 1'b0;
        streamLast  = 1'b0;
        streamData  = '0;
        readS       = '0;
        readT       = '0;
        clampS      = 1'b0;
        clampT      = 1'b0;
        widthLog2   = '0;
        heightLog2  = '0;
        resetAndReady();
        loadAndRead();
        colourExpansion();
        wrapAndClamp();
        subCoordinates();
        restartOnLast();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* textureBuffer.f */
rtl/texturePkg.sv
rtl/textureLoader.sv
rtl/texelBank.sv
rtl/quadAddressGen.sv
rtl/quadAssembler.sv
rtl/textureBuffer.sv
test/textureBufferTb.sv
